//--- common/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// cache geometry, direct mapped
`define FETCH_LINE_WORDS 4
`define FETCH_LINES      16

// field widths of a word address, must match the geometry above
`define FETCH_OFF_BITS 2
`define FETCH_IDX_BITS 4
`define FETCH_TAG_BITS 24

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`define FETCH_RESET_PC 32'h0000_0000

`endif

//--- common/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    // byte address as seen by the pipeline
    typedef logic [31:0] pc_t;

    // pc without the two byte-select bits
    typedef logic [29:0] word_addr_t;

    typedef logic [31:0] instr_t;

    // word address = {tag, index, offset}
    typedef logic [`FETCH_IDX_BITS-1:0] line_idx_t;
    typedef logic [`FETCH_OFF_BITS-1:0] word_off_t;
    typedef logic [`FETCH_TAG_BITS-1:0] tag_t;

    // refill master states
    typedef enum logic [1:0] {
        refill_idle, // waiting for a miss
        refill_bus,  // wishbone cycle open
        refill_done  // last word handed over, line closes
    } refill_state_t;

endpackage

//--- icache/wb_refill.sv
`include "fetch_cfg.svh"

module wb_refill
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       refill_start,
    input  word_addr_t refill_base,
    output logic       refill_we,
    output word_off_t  refill_off,
    output instr_t     refill_data,
    output logic       refill_end,
    output logic       wb_cyc,
    output logic       wb_stb,
    output word_addr_t wb_adr,
    input  instr_t     wb_dat_i,
    input  logic       wb_ack
);

    refill_state_t state_r;
    refill_state_t state_next;

    tag_t      tag_r;
    line_idx_t idx_r;
    word_off_t off_r;       // word currently on the bus
    logic      start_go;
    logic      word_taken;
    logic      last_word;

    logic      we_r;
    word_off_t wr_off_r;
    instr_t    wr_data_r;

    assign start_go   = (state_r == refill_idle) && refill_start;
    assign word_taken = (state_r == refill_bus) && wb_ack;
    assign last_word  = (off_r == word_off_t'(`FETCH_LINE_WORDS - 1));

    // cyc and stb rise and fall together, address stays put until ack
    assign wb_cyc = (state_r == refill_bus);
    assign wb_stb = (state_r == refill_bus);
    assign wb_adr = {tag_r, idx_r, off_r};

    assign refill_we   = we_r;
    assign refill_off  = wr_off_r;
    assign refill_data = wr_data_r;
    assign refill_end  = (state_r == refill_done); // lines up with the last word write

    always_comb begin
        state_next = state_r;
        case (state_r)
            refill_idle: begin
                if (refill_start) begin
                    state_next = refill_bus;
                end
            end
            refill_bus: begin
                if (wb_ack && last_word) begin
                    state_next = refill_done;
                end
            end
            refill_done: state_next = refill_idle;
            default:     state_next = refill_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_r <= refill_idle;
            off_r   <= '0;
            we_r    <= 1'b0;
        end else begin
            state_r <= state_next;
            we_r    <= word_taken;
            if (start_go) begin
                off_r <= '0;
            end else if (word_taken) begin
                off_r <= off_r + 1'b1;    // wraps to 0 after the last word
            end
        end
    end

    // line address and the word handed to the cache
    always_ff @(posedge clk) begin
        if (start_go) begin
            tag_r <= tag_t'(refill_base >> (`FETCH_IDX_BITS + `FETCH_OFF_BITS));
            idx_r <= line_idx_t'(refill_base >> `FETCH_OFF_BITS);
        end
        if (word_taken) begin
            wr_off_r  <= off_r;
            wr_data_r <= wb_dat_i;
        end
    end

endmodule

//--- icache/icache.sv
`include "fetch_cfg.svh"

module icache
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_addr_t i_addr,
    output instr_t     i_instr,
    output logic       memory_stall,
    output logic       refill_start,
    output word_addr_t refill_base,
    input  logic       refill_we,
    input  word_off_t  refill_off,
    input  instr_t     refill_data,
    input  logic       refill_end
);

    // storage
    tag_t                    tag_mem  [`FETCH_LINES];
    instr_t                  data_mem [`FETCH_LINES][`FETCH_LINE_WORDS];
    logic [`FETCH_LINES-1:0] valid_r;

    // lookup fields
    tag_t      req_tag;
    line_idx_t req_idx;
    word_off_t req_off;
    logic      hit;
    logic      miss_go;

    // refill bookkeeping
    logic      refill_pending;
    logic      refill_start_r;
    tag_t      miss_tag_r;
    line_idx_t miss_idx_r;

    assign {req_tag, req_idx, req_off} = i_addr;

    // hit is answered in the same cycle
    assign hit     = valid_r[req_idx] && (tag_mem[req_idx] == req_tag);
    assign i_instr = data_mem[req_idx][req_off];

    assign memory_stall = !hit;

    // first cycle of a miss that has no request out yet
    assign miss_go = !hit && !refill_pending;

    assign refill_start = refill_start_r;
    assign refill_base  = {miss_tag_r, miss_idx_r, word_off_t'(0)}; // line start

    // request tracking, one refill per miss
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refill_pending <= 1'b0;
            refill_start_r <= 1'b0;
        end else begin
            refill_start_r <= 1'b0;
            if (miss_go) begin
                refill_pending <= 1'b1;
                refill_start_r <= 1'b1;   // one-cycle pulse
            end else if (refill_end) begin
                refill_pending <= 1'b0;
            end
        end
    end

    // line being refilled, held until refill_end
    always_ff @(posedge clk) begin
        if (miss_go) begin
            miss_tag_r <= req_tag;
            miss_idx_r <= req_idx;
        end
    end

    // incoming words go straight into the data array
    always_ff @(posedge clk) begin
        if (refill_we) begin
            data_mem[miss_idx_r][refill_off] <= refill_data;
        end
    end

    // tag written once the whole line is in
    always_ff @(posedge clk) begin
        if (refill_end) begin
            tag_mem[miss_idx_r] <= miss_tag_r;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= '0;
        end else if (miss_go) begin
            valid_r[req_idx] <= 1'b0;     // old line in this slot is being replaced
        end else if (refill_end) begin
            valid_r[miss_idx_r] <= 1'b1;
        end
    end

endmodule

//--- instruction_fetch/instruction_fetch.sv
`include "fetch_cfg.svh"

module instruction_fetch
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       memory_stall,
    input  logic       pc_hold,
    input  logic       if_flush,
    input  logic       pc_src,
    input  pc_t        branch_target,
    input  instr_t     if_dwrite,
    input  instr_t     i_instr,
    output word_addr_t i_addr,
    output pc_t        if_id_pc,
    output instr_t     if_id_instr
);

    pc_t    pc_r;
    pc_t    pc_next;
    pc_t    if_id_pc_r;
    pc_t    if_id_pc_next;
    instr_t if_id_instr_r;
    instr_t if_id_instr_next;

    // always fetching, the cache sees the current pc
    assign i_addr = pc_r[31:2];

    assign if_id_pc    = if_id_pc_r;
    assign if_id_instr = if_id_instr_r;

    // next pc
    always_comb begin
        if (memory_stall || pc_hold) begin
            pc_next = pc_r;            // frozen
        end else if (pc_src) begin
            pc_next = branch_target;   // taken branch
        end else begin
            pc_next = pc_r + 32'd4;
        end
    end

    // if/id pc field
    always_comb begin
        if (memory_stall) begin
            if_id_pc_next = if_id_pc_r;
        end else if (pc_hold) begin
            if_id_pc_next = pc_r - 32'd4; // load-use replay of the older pc
        end else if (if_flush) begin
            if_id_pc_next = 32'd0;
        end else begin
            if_id_pc_next = pc_r;
        end
    end

    // if/id instruction field, same priority as the pc field
    always_comb begin
        if (memory_stall) begin
            if_id_instr_next = if_id_instr_r;
        end else if (pc_hold) begin
            if_id_instr_next = if_dwrite;
        end else if (if_flush) begin
            if_id_instr_next = `FETCH_NOP; // bubble after a taken branch
        end else begin
            if_id_instr_next = i_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_r          <= `FETCH_RESET_PC;
            if_id_pc_r    <= '0;
            if_id_instr_r <= '0;
        end else begin
            pc_r          <= pc_next;
            if_id_pc_r    <= if_id_pc_next;
            if_id_instr_r <= if_id_instr_next;
        end
    end

endmodule

//--- rtl/fetch_top.sv
`include "fetch_cfg.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_hold,
    input  logic       if_flush,
    input  logic       pc_src,
    input  pc_t        branch_target,
    input  instr_t     if_dwrite,
    output pc_t        if_id_pc,
    output instr_t     if_id_instr,
    output logic       memory_stall,
    // wishbone classic master, read only so no wb_we
    output logic       wb_cyc,
    output logic       wb_stb,
    output word_addr_t wb_adr,
    input  instr_t     wb_dat_i,
    input  logic       wb_ack
);

    // fetch <-> cache
    word_addr_t i_addr;
    instr_t     i_instr;

    // cache <-> refill master
    logic       refill_start;
    word_addr_t refill_base;
    logic       refill_we;
    word_off_t  refill_off;
    instr_t     refill_data;
    logic       refill_end;

    wb_refill refill_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .refill_start (refill_start),
        .refill_base  (refill_base),
        .refill_we    (refill_we),
        .refill_off   (refill_off),
        .refill_data  (refill_data),
        .refill_end   (refill_end),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack)
    );

    icache icache_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_addr       (i_addr),
        .i_instr      (i_instr),
        .memory_stall (memory_stall),
        .refill_start (refill_start),
        .refill_base  (refill_base),
        .refill_we    (refill_we),
        .refill_off   (refill_off),
        .refill_data  (refill_data),
        .refill_end   (refill_end)
    );

    instruction_fetch fetch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .memory_stall  (memory_stall),
        .pc_hold       (pc_hold),
        .if_flush      (if_flush),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .if_dwrite     (if_dwrite),
        .i_instr       (i_instr),
        .i_addr        (i_addr),
        .if_id_pc      (if_id_pc),
        .if_id_instr   (if_id_instr)
    );

endmodule

//--- testbench/wb_mem_model.sv
module wb_mem_model
    import fetch_pkg::*;
#(
    parameter int unsigned rand_seed = 32'h8c16_d775
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  word_addr_t wb_adr,
    output instr_t     wb_dat_o,
    output logic       wb_ack,
    output int         ack_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0]  wait_tab [256];   // wait states per access, drawn once
    logic [1:0]  wait_cnt;

    initial begin
        void'($urandom(rand_seed));
        for (int i = 0; i < 256; i++) begin
            wait_tab[i] = 2'($urandom_range(3, 0));
        end
    end

    // word at address A is A xor 0x5a5a_0000
    assign wb_dat_o = {2'b00, wb_adr} ^ 32'h5a5a_0000;
    assign wb_ack   = wb_cyc && wb_stb && (wait_cnt == wait_tab[ack_count[7:0]]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt  <= '0;
            ack_count <= 0;
        end else if (wb_ack) begin
            wait_cnt  <= '0;
            ack_count <= ack_count + 1;
        end else if (wb_cyc && wb_stb) begin
            wait_cnt <= wait_cnt + 1'b1; // still in wait states
        end
    end

endmodule

//--- testbench/fetch_props.sv
module fetch_props
    import fetch_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input word_addr_t wb_adr,
    input logic       wb_ack,
    input logic       memory_stall
);
    timeunit 1ns;
    timeprecision 100ps;

    int prop_errors = 0;

    // strobe only inside a bus cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            prop_errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else begin
            $error("wishbone request changed before ack");
            prop_errors++;
        end

    assert property (@(posedge clk) !rst_n |=> !wb_cyc && !wb_stb)
        else begin
            $error("wishbone not idle in reset");
            prop_errors++;
        end

    // no bus traffic while the pipeline runs
    assert property (@(posedge clk) disable iff (!rst_n) !memory_stall |-> !wb_cyc)
        else begin
            $error("bus cycle open while memory_stall is low");
            prop_errors++;
        end

    // line is valid right after the bus cycle closes
    assert property (@(posedge clk) disable iff (!rst_n) $fell(wb_cyc) |=> !memory_stall)
        else begin
            $error("memory_stall still high after refill finished");
            prop_errors++;
        end

endmodule

bind fetch_top fetch_props props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .memory_stall (memory_stall)
);

//--- testbench/fetch_tb.sv
`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned rand_seed = 32'h8c16_d775;
    localparam int max_wait  = 200;
    localparam int num_rows  = 22;
    localparam int num_tests = 4;

    typedef struct packed {
        logic [1:0] test;
        logic       hold;
        logic       flush;
        logic       src;
        pc_t        target;
        instr_t     replay;
        logic [3:0] acks;   // bus acks spent before this pc hits
    } row_t;

    // test, hold, flush, src, branch_target, replay word, acks
    row_t rows [num_rows] = '{
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd4}, // pc 0x000
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd4}, // pc 0x010, line 1
        '{2'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd1, 1'b0, 1'b0, 1'b1, 32'h0000_0120, 32'h0000_0000, 4'd0}, // pc 0x018
        '{2'd1, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd4}, // pc 0x120, line 2
        '{2'd2, 1'b0, 1'b1, 1'b1, 32'h0000_0008, 32'h0000_0000, 4'd0}, // loop back
        '{2'd2, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0}, // pc 0x008 hits
        '{2'd2, 1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'hdead_beef, 4'd0},
        '{2'd2, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd2, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd2, 1'b1, 1'b1, 1'b0, 32'h0000_0000, 32'h1234_5678, 4'd0}, // hold beats flush
        '{2'd2, 1'b0, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd3, 1'b0, 1'b0, 1'b1, 32'h0000_0500, 32'h0000_0000, 4'd0}, // pc 0x018
        '{2'd3, 1'b0, 1'b0, 1'b1, 32'h0000_0004, 32'h0000_0000, 4'd4}, // index 0, tag 5
        '{2'd3, 1'b0, 1'b0, 1'b1, 32'h0000_0504, 32'h0000_0000, 4'd4}, // index 0, tag 0
        '{2'd3, 1'b0, 1'b0, 1'b1, 32'h0000_0008, 32'h0000_0000, 4'd4},
        '{2'd3, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd4},
        '{2'd3, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0},
        '{2'd3, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'd0}  // line 1 survived
    };

    string test_names [num_tests] = '{
        "reset and sequential fetch",
        "taken branch to another line",
        "flush, hold and loop revisit",
        "conflict eviction"
    };

    logic       clk;
    logic       rst_n;
    logic       pc_hold;
    logic       if_flush;
    logic       pc_src;
    pc_t        branch_target;
    instr_t     if_dwrite;
    pc_t        if_id_pc;
    instr_t     if_id_instr;
    logic       memory_stall;
    logic       wb_cyc;
    logic       wb_stb;
    word_addr_t wb_adr;
    instr_t     wb_dat;
    logic       wb_ack;
    int         ack_count;

    pc_t    ref_pc;     // pc the fetch stage should present
    pc_t    exp_pc;
    instr_t exp_instr;
    int     acks_before;
    int     checks;
    int     errors;
    int     test_checks;
    int     test_errors;
    logic   timed_out;

    fetch_top fetch_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_hold       (pc_hold),
        .if_flush      (if_flush),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .if_dwrite     (if_dwrite),
        .if_id_pc      (if_id_pc),
        .if_id_instr   (if_id_instr),
        .memory_stall  (memory_stall),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack        (wb_ack)
    );

    wb_mem_model #(.rand_seed(rand_seed)) mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat),
        .wb_ack    (wb_ack),
        .ack_count (ack_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory contents as seen through the bus
    function automatic instr_t expected_word(pc_t pc);
        return {2'b00, pc[31:2]} ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(string what, int row, logic [31:0] got, logic [31:0] exp);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: row %0d %s got %h expected %h",
                     $time, row, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic drive_idle();
        pc_hold       = 1'b0;
        if_flush      = 1'b0;
        pc_src        = 1'b0;
        branch_target = '0;
        if_dwrite     = '0;
    endtask

    // ok drops if the refill never finishes
    task automatic wait_stall_low(output logic ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (ok && memory_stall !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > max_wait) begin
                ok = 1'b0;
            end
        end
    endtask

    // hold first, then flush, then the fetched word
    task automatic predict_step(row_t r);
        if (r.hold) begin
            exp_pc    = ref_pc - 32'd4;
            exp_instr = r.replay;
        end else begin
            if (r.flush) begin
                exp_pc    = 32'd0;
                exp_instr = `FETCH_NOP;
            end else begin
                exp_pc    = ref_pc;
                exp_instr = expected_word(ref_pc);
            end
            ref_pc = r.src ? r.target : ref_pc + 32'd4;
        end
    endtask

    initial begin
        logic ok;
        int   total;
        rst_n       = 1'b0;
        drive_idle();
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        ref_pc      = `FETCH_RESET_PC;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // nothing fetched and bus idle before the first miss
        check_value("wb_cyc after reset", -1, {31'b0, wb_cyc}, 32'd0);
        check_value("if_id_pc after reset", -1, if_id_pc, 32'd0);
        check_value("if_id_instr after reset", -1, if_id_instr, 32'd0);
        check_value("acks after reset", -1, ack_count, 32'd0);

        for (int i = 0; i < num_rows && !timed_out; i++) begin
            acks_before = ack_count;
            wait_stall_low(ok);
            if (!ok) begin
                $display("timeout: memory_stall still high after %0d cycles before row %0d",
                         max_wait, i);
                timed_out = 1'b1;
            end else begin
                check_value("refill acks", i, ack_count - acks_before, 32'(rows[i].acks));
                pc_hold       = rows[i].hold;
                if_flush      = rows[i].flush;
                pc_src        = rows[i].src;
                branch_target = rows[i].target;
                if_dwrite     = rows[i].replay;
                predict_step(rows[i]);
                @(posedge clk);
                #1;
                check_value("if_id_pc", i, if_id_pc, exp_pc);
                check_value("if_id_instr", i, if_id_instr, exp_instr);
                drive_idle();
                if (i == num_rows - 1 || rows[i + 1].test != rows[i].test) begin
                    $display("test %0d %s: %0d checks, %0d errors", rows[i].test,
                             test_names[rows[i].test], test_checks, test_errors);
                    test_checks = 0;
                    test_errors = 0;
                end
            end
        end

        total = errors + fetch_top_i.props_i.prop_errors;
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 checks, errors, fetch_top_i.props_i.prop_errors);
        if (!timed_out && total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/fetch_pkg.sv
icache/wb_refill.sv
icache/icache.sv
instruction_fetch/instruction_fetch.sv
rtl/fetch_top.sv
testbench/wb_mem_model.sv
testbench/fetch_props.sv
testbench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_pkg.sv
      - icache/wb_refill.sv
      - icache/icache.sv
      - instruction_fetch/instruction_fetch.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/wb_mem_model.sv
      - testbench/fetch_props.sv
      - testbench/fetch_tb.sv
